//--- include/nic_ctrl_params.svh
// Widths, reset defaults and countdown length shared by the NIC control packages and RTL
`ifndef NIC_CTRL_PARAMS_SVH
`define NIC_CTRL_PARAMS_SVH

// ==============================
// Register port widths
// ==============================

// One register word on the request port
`define NIC_REG_DATA_W 32

// Register number carried with each request
`define NIC_REG_INDEX_W 8

// Base, size, packet count and counters are split into two words
`define NIC_WIDE_W 64

// ==============================
// Buffer output stream
// ==============================

// Full beat of the monitored stream
`define NIC_SEQ_TDATA_W 512

// Generator sequence number sits in the top bits of each beat
`define NIC_SEQ_FIELD_W 32

// ==============================
// Reset values and timing
// ==============================

// Clock cycles that resetn_out stays low after a software reset
`define NIC_RESET_CYCLES 1000

// Host buffer defaults to a 4 GB window at 4 GB
`define NIC_PCI_BASE_DEFAULT 64'h0000_0001_0000_0000
`define NIC_PCI_SIZE_DEFAULT 64'h0000_0001_0000_0000

`endif

//--- design/nic_reg_pkg.sv
// Register map, response codes and request/response structs of the NIC register port
`include "nic_ctrl_params.svh"

package nic_reg_pkg;

    // One data word and one register number on the port
    typedef logic [`NIC_REG_DATA_W-1:0]  reg_word_t;
    typedef logic [`NIC_REG_INDEX_W-1:0] reg_idx_t;

    // ==============================
    // Register map
    // ==============================
    typedef enum logic [`NIC_REG_INDEX_W-1:0] {
        REG_STATUS         = 8'd0,
        REG_ERRORS         = 8'd1,
        REG_GOOD_H         = 8'd2,
        REG_GOOD_L         = 8'd3,
        REG_BAD_H          = 8'd4,
        REG_BAD_L          = 8'd5,
        REG_PCI_BASE_H     = 8'd6,
        REG_PCI_BASE_L     = 8'd7,
        REG_PCI_SIZE_H     = 8'd8,
        REG_PCI_SIZE_L     = 8'd9,
        REG_RESET          = 8'd10,
        REG_CLEAR_COUNTERS = 8'd11,
        REG_PACKET_COUNT_H = 8'd32,
        REG_PACKET_COUNT_L = 8'd33,
        REG_LOOPBACK       = 8'd34,
        REG_PAUSE_PCI      = 8'd35
    } reg_index_e;

    // Bus response codes, same encoding as AXI BRESP/RRESP
    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2,
        DECERR = 2'd3
    } reg_resp_e;

    // Request side, write and read may share a cycle
    typedef struct packed {
        logic      write;
        reg_idx_t  write_index;
        reg_word_t write_data;
        logic      read;
        reg_idx_t  read_index;
    } reg_req_t;

    // Response side, both halves one cycle after their strobe
    typedef struct packed {
        logic      write_done;
        reg_resp_e write_resp;
        logic      read_valid;
        reg_word_t read_data;
        reg_resp_e read_resp;
    } reg_rsp_t;

    // Settings handed to the datapath
    typedef struct packed {
        logic [`NIC_WIDE_W-1:0] pci_base;
        logic [`NIC_WIDE_W-1:0] pci_size;
        logic [`NIC_WIDE_W-1:0] packet_count;
        logic                   loopback;
    } ctrl_config_t;

endpackage

//--- design/nic_status_pkg.sv
// Types for packet events, the monitored stream, error flags and packet counters
`include "nic_ctrl_params.svh"

package nic_status_pkg;

    // ==============================
    // Inputs from the datapath
    // ==============================

    // Single-cycle strobes, one per received packet
    typedef struct packed {
        logic good;
        logic bad;
        // Packet targeted an address outside the host buffer
        logic range_err;
    } packet_events_t;

    // One beat of the buffer output stream, observed only
    typedef struct packed {
        logic [`NIC_SEQ_TDATA_W-1:0] tdata;
        logic                        tvalid;
        logic                        tready;
    } seq_beat_t;

    // ==============================
    // Status back to the register port
    // ==============================

    // Bit order matches the ERRORS register, bit 0 is pci_range_err
    typedef struct packed {
        logic seq_error;
        logic overflow_1;
        logic overflow_0;
        logic pci_range_err;
    } error_flags_t;

    // Running packet totals
    typedef struct packed {
        logic [`NIC_WIDE_W-1:0] good_packets;
        logic [`NIC_WIDE_W-1:0] bad_packets;
    } status_counters_t;

endpackage

//--- design/ctrl_regs.sv
// Write side of the NIC register block: config registers, start/clear pulses and countdowns
`timescale 1ns/10ps
`include "nic_ctrl_params.svh"

module ctrl_regs (
    input  logic                      clk,
    input  logic                      resetn,
    input  nic_reg_pkg::reg_req_t     req,
    output logic                      write_done,
    output nic_reg_pkg::reg_resp_e    write_resp,
    output logic                      gen_packets,
    output logic                      pause_pci,
    output logic                      reset_active,
    output logic                      clear_counters,
    output logic                      resetn_out,
    output nic_reg_pkg::ctrl_config_t cfg
);
    import nic_reg_pkg::*;

    localparam int wide_w      = `NIC_WIDE_W;
    localparam int dw          = `NIC_REG_DATA_W;
    localparam int reset_cnt_w = $clog2(`NIC_RESET_CYCLES + 1);

    // Remaining cycles of software reset
    logic [reset_cnt_w-1:0] reset_count;

    // Remaining cycles of PCI pause
    reg_word_t pause_count;

    // Both countdowns are active while nonzero
    assign reset_active = (reset_count != '0);
    assign pause_pci    = (pause_count != '0);

    // ==============================
    // Reset output
    // ==============================

    // Low during external reset and while the software countdown runs
    always_ff @(posedge clk) begin
        resetn_out <= resetn && !reset_active;
    end

    // ==============================
    // Write decode
    // ==============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            write_done       <= 1'b0;
            write_resp       <= OKAY;
            gen_packets      <= 1'b0;
            clear_counters   <= 1'b0;
            reset_count      <= '0;
            pause_count      <= '0;
            cfg.pci_base     <= `NIC_PCI_BASE_DEFAULT;
            cfg.pci_size     <= `NIC_PCI_SIZE_DEFAULT;
            cfg.packet_count <= '0;
            cfg.loopback     <= 1'b0;
        end else begin
            // Response follows every write strobe by one cycle
            write_done     <= req.write;
            // Pulses default low
            gen_packets    <= 1'b0;
            clear_counters <= 1'b0;

            // Free-running countdowns, a write below reloads them
            if (reset_active) begin
                reset_count <= reset_count - 1'b1;
            end
            if (pause_pci) begin
                pause_count <= pause_count - 1'b1;
            end

            if (req.write) begin
                write_resp <= OKAY;
                case (req.write_index)
                    REG_PACKET_COUNT_H: cfg.packet_count[wide_w-1:dw] <= req.write_data;
                    // Low word write also launches the generator
                    REG_PACKET_COUNT_L: begin
                        cfg.packet_count[dw-1:0] <= req.write_data;
                        gen_packets              <= 1'b1;
                    end
                    REG_PCI_BASE_H:     cfg.pci_base[wide_w-1:dw] <= req.write_data;
                    REG_PCI_BASE_L:     cfg.pci_base[dw-1:0]      <= req.write_data;
                    REG_PCI_SIZE_H:     cfg.pci_size[wide_w-1:dw] <= req.write_data;
                    REG_PCI_SIZE_L:     cfg.pci_size[dw-1:0]      <= req.write_data;
                    REG_LOOPBACK:       cfg.loopback              <= req.write_data[0];
                    // Data is ignored, any write starts the reset
                    REG_RESET:          reset_count <= reset_cnt_w'(`NIC_RESET_CYCLES);
                    REG_PAUSE_PCI:      pause_count <= req.write_data;
                    REG_CLEAR_COUNTERS: clear_counters <= 1'b1;
                    // Unmapped or read-only, nothing changes
                    default:            write_resp <= DECERR;
                endcase
            end
        end
    end

    // ==============================
    // Checks
    // ==============================

    // Generator start is one cycle wide, so no back-to-back PACKET_COUNT_L writes
    a_gen_single: assert property (@(posedge clk) disable iff (!resetn)
        gen_packets |=> !gen_packets);

    // Status clear is one cycle wide as seen by the monitor
    a_clear_single: assert property (@(posedge clk) disable iff (!resetn)
        clear_counters |=> !clear_counters);

endmodule

//--- design/status_monitor.sv
// Packet counters, sticky error flags and the sequence checker on the buffer output stream
`timescale 1ns/10ps
`include "nic_ctrl_params.svh"

module status_monitor (
    input  logic                              clk,
    input  logic                              resetn_out,
    input  logic                              clear_counters,
    input  nic_status_pkg::packet_events_t    events,
    input  nic_status_pkg::seq_beat_t         seq,
    input  logic                              overflow_0,
    input  logic                              overflow_1,
    output nic_status_pkg::status_counters_t  counters,
    output nic_status_pkg::error_flags_t      errors
);

    // Software clear or any reset wipes the status
    logic clear;

    // Sticky flags
    logic pci_range_err;
    logic seq_error;

    // Stream handshake and the sequence field it carries
    logic                        beat;
    logic [`NIC_SEQ_FIELD_W-1:0] seq_field;
    logic [`NIC_SEQ_FIELD_W-1:0] seq_prior;

    assign clear     = !resetn_out || clear_counters;
    assign beat      = seq.tvalid && seq.tready;
    // Top bits of the beat
    assign seq_field = seq.tdata[`NIC_SEQ_TDATA_W-1 -: `NIC_SEQ_FIELD_W];

    // ==============================
    // Packet counters
    // ==============================
    always_ff @(posedge clk) begin
        if (clear) begin
            counters <= '0;
        end else begin
            if (events.good) begin
                counters.good_packets <= counters.good_packets + 1'b1;
            end
            if (events.bad) begin
                counters.bad_packets <= counters.bad_packets + 1'b1;
            end
        end
    end

    // ==============================
    // Address range errors
    // ==============================
    always_ff @(posedge clk) begin
        if (clear) begin
            pci_range_err <= 1'b0;
        end else if (events.range_err) begin
            pci_range_err <= 1'b1;
        end
    end

    // ==============================
    // Sequence checker
    // ==============================

    // Generator data counts up from 0
    // A zero field restarts the sequence, anything else must be prior plus one
    always_ff @(posedge clk) begin
        if (clear) begin
            seq_error <= 1'b0;
        end else if (beat) begin
            if (seq_field != '0 && seq_field != seq_prior + 1'b1) begin
                seq_error <= 1'b1;
            end
        end
    end

    // Last field seen on the stream
    always_ff @(posedge clk) begin
        if (beat) begin
            seq_prior <= seq_field;
        end
    end

    // Overflow inputs pass through live, the others are sticky
    assign errors = '{
        seq_error:     seq_error,
        overflow_1:    overflow_1,
        overflow_0:    overflow_0,
        pci_range_err: pci_range_err
    };

    // Once flagged, a sequence error survives until clear or reset
    a_seq_sticky: assert property (@(posedge clk)
        seq_error && resetn_out && !clear_counters |=> seq_error);

endmodule

//--- design/reg_read_mux.sv
// Read side of the NIC register block: selects one status or config word per read request
`timescale 1ns/10ps
`include "nic_ctrl_params.svh"

module reg_read_mux (
    input  logic                             clk,
    input  logic                             resetn,
    input  nic_reg_pkg::reg_req_t            req,
    input  nic_reg_pkg::ctrl_config_t        cfg,
    input  logic                             pause_pci,
    input  logic                             reset_active,
    input  logic                             generator_idle,
    input  logic                             hbm_cattrip,
    input  logic                             pcs_aligned,
    input  nic_status_pkg::status_counters_t counters,
    input  nic_status_pkg::error_flags_t     errors,
    output logic                             read_valid,
    output nic_reg_pkg::reg_word_t           read_data,
    output nic_reg_pkg::reg_resp_e           read_resp
);
    import nic_reg_pkg::*;

    localparam int wide_w = `NIC_WIDE_W;
    localparam int dw     = `NIC_REG_DATA_W;

    // Next read word and response
    reg_word_t rd_word;
    reg_resp_e rd_resp;

    // HBM within its temperature limits
    logic temp_ok;

    assign temp_ok = !hbm_cattrip;

    // ==============================
    // Read decode
    // ==============================
    always_comb begin
        rd_word = '0;
        rd_resp = OKAY;
        case (req.read_index)
            REG_STATUS:         rd_word = reg_word_t'({temp_ok, pcs_aligned});
            REG_ERRORS:         rd_word = reg_word_t'(errors);
            REG_GOOD_H:         rd_word = counters.good_packets[wide_w-1:dw];
            REG_GOOD_L:         rd_word = counters.good_packets[dw-1:0];
            REG_BAD_H:          rd_word = counters.bad_packets[wide_w-1:dw];
            REG_BAD_L:          rd_word = counters.bad_packets[dw-1:0];
            REG_PCI_BASE_H:     rd_word = cfg.pci_base[wide_w-1:dw];
            REG_PCI_BASE_L:     rd_word = cfg.pci_base[dw-1:0];
            REG_PCI_SIZE_H:     rd_word = cfg.pci_size[wide_w-1:dw];
            REG_PCI_SIZE_L:     rd_word = cfg.pci_size[dw-1:0];
            REG_RESET:          rd_word = reg_word_t'(reset_active);
            // Count is write-only, reads report generator busy instead
            REG_PACKET_COUNT_H: rd_word = '0;
            REG_PACKET_COUNT_L: rd_word = reg_word_t'(!generator_idle);
            REG_LOOPBACK:       rd_word = reg_word_t'(cfg.loopback);
            REG_PAUSE_PCI:      rd_word = reg_word_t'(pause_pci);
            // CLEAR_COUNTERS and unmapped indices, data stays 0
            default:            rd_resp = DECERR;
        endcase
    end

    // ==============================
    // Registered response
    // ==============================
    always_ff @(posedge clk) begin
        if (!resetn) begin
            read_valid <= 1'b0;
        end else begin
            read_valid <= req.read;
        end
    end

    // Word held until the next read
    always_ff @(posedge clk) begin
        if (req.read) begin
            read_data <= rd_word;
            read_resp <= rd_resp;
        end
    end

endmodule

//--- design/nic_control.sv
// Top of the NIC status and control block, connects write side, status monitor and read mux
`timescale 1ns/10ps

module nic_control (
    input  logic                           clk,
    input  logic                           resetn,
    input  nic_reg_pkg::reg_req_t          req,
    output nic_reg_pkg::reg_rsp_t          rsp,
    input  nic_status_pkg::packet_events_t events,
    input  nic_status_pkg::seq_beat_t      seq,
    input  logic                           overflow_0,
    input  logic                           overflow_1,
    input  logic                           hbm_cattrip,
    input  logic                           pcs_aligned,
    input  logic                           generator_idle,
    output nic_reg_pkg::ctrl_config_t      cfg,
    output logic                           gen_packets,
    output logic                           pause_pci,
    output logic                           resetn_out
);
    import nic_reg_pkg::*;
    import nic_status_pkg::*;

    // Write half of the response
    logic      write_done;
    reg_resp_e write_resp;

    // Control to status and read side
    logic reset_active;
    logic clear_counters;

    // Status to read side
    status_counters_t counters;
    error_flags_t     errors;

    // Read half of the response
    logic      read_valid;
    reg_word_t read_data;
    reg_resp_e read_resp;

    // ==============================
    // Write side and countdowns
    // ==============================
    ctrl_regs ctrl_regs_i (
        .clk            (clk),
        .resetn         (resetn),
        .req            (req),
        .write_done     (write_done),
        .write_resp     (write_resp),
        .gen_packets    (gen_packets),
        .pause_pci      (pause_pci),
        .reset_active   (reset_active),
        .clear_counters (clear_counters),
        .resetn_out     (resetn_out),
        .cfg            (cfg)
    );

    // Counters and flags run on the software reset
    status_monitor status_monitor_i (
        .clk            (clk),
        .resetn_out     (resetn_out),
        .clear_counters (clear_counters),
        .events         (events),
        .seq            (seq),
        .overflow_0     (overflow_0),
        .overflow_1     (overflow_1),
        .counters       (counters),
        .errors         (errors)
    );

    // ==============================
    // Read side
    // ==============================
    reg_read_mux reg_read_mux_i (
        .clk            (clk),
        .resetn         (resetn),
        .req            (req),
        .cfg            (cfg),
        .pause_pci      (pause_pci),
        .reset_active   (reset_active),
        .generator_idle (generator_idle),
        .hbm_cattrip    (hbm_cattrip),
        .pcs_aligned    (pcs_aligned),
        .counters       (counters),
        .errors         (errors),
        .read_valid     (read_valid),
        .read_data      (read_data),
        .read_resp      (read_resp)
    );

    // Both halves go out on one response struct
    assign rsp = '{
        write_done: write_done,
        write_resp: write_resp,
        read_valid: read_valid,
        read_data:  read_data,
        read_resp:  read_resp
    };

endmodule

//--- sim/clk_gen.sv
// Testbench clock and reset source, instantiated once by the NIC control testbench
`timescale 1ns/10ps

module clk_gen #(
    parameter int half_period  = 4,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic resetn
);

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Reset released on a falling edge, away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

//--- sim/nic_control_tb.sv
// Testbench for the NIC control block that replays the register vectors and checks pulse timing
`timescale 1ns/10ps
`include "nic_ctrl_params.svh"

module nic_control_tb;
    import nic_reg_pkg::*;
    import nic_status_pkg::*;

    logic             clk;
    logic             resetn;
    reg_req_t         req;
    reg_rsp_t         rsp;
    packet_events_t   events;
    seq_beat_t        seq;
    logic             overflow_0;
    logic             overflow_1;
    logic             hbm_cattrip;
    logic             pcs_aligned;
    logic             generator_idle;
    ctrl_config_t     cfg;
    logic             gen_packets;
    logic             pause_pci;
    logic             resetn_out;

    // Vector table with one entry per data line
    logic [7:0]  op_q[$];
    logic [7:0]  idx_q[$];
    logic [31:0] data_q[$];
    logic [63:0] exp_q[$];
    bit          vectors_loaded;

    // Reference packet totals
    logic [63:0] good_total;
    logic [63:0] bad_total;
    logic [31:0] rnd;
    int          error_count;
    string       test_name;

    clk_gen clk_gen_i (
        .clk    (clk),
        .resetn (resetn)
    );

    nic_control dut_i (
        .clk            (clk),
        .resetn         (resetn),
        .req            (req),
        .rsp            (rsp),
        .events         (events),
        .seq            (seq),
        .overflow_0     (overflow_0),
        .overflow_1     (overflow_1),
        .hbm_cattrip    (hbm_cattrip),
        .pcs_aligned    (pcs_aligned),
        .generator_idle (generator_idle),
        .cfg            (cfg),
        .gen_packets    (gen_packets),
        .pause_pci      (pause_pci),
        .resetn_out     (resetn_out)
    );

    // ==============================
    // Helpers
    // ==============================

    // Numerical Recipes LCG constants
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            abort_run($sformatf("Fail %s %s: expected %h, actual %h",
                                test_name, what, expected, actual));
        end
    endtask

    // Nothing pending between operations
    task automatic check_idle();
        check("write_done idle", 64'd0, 64'(rsp.write_done));
        check("read_valid idle", 64'd0, 64'(rsp.read_valid));
        check("gen_packets idle", 64'd0, 64'(gen_packets));
        check("pause_pci idle", 64'd0, 64'(pause_pci));
        check("resetn_out idle", 64'd1, 64'(resetn_out));
    endtask

    // Response must follow the strobe by exactly one cycle
    task automatic write_reg(input logic [7:0] index, input logic [31:0] value,
                             input logic [1:0] exp_resp);
        @(negedge clk);
        check_idle();
        req.write       = 1'b1;
        req.write_index = index;
        req.write_data  = value;
        @(negedge clk);
        req.write = 1'b0;
        check("write_done", 64'd1, 64'(rsp.write_done));
        check("write_resp", 64'(exp_resp), 64'(rsp.write_resp));
        check("gen_packets", 64'(index == REG_PACKET_COUNT_L), 64'(gen_packets));
    endtask

    task automatic read_reg(input logic [7:0] index, input logic [31:0] exp_data,
                            input logic [1:0] exp_resp);
        @(negedge clk);
        check_idle();
        req.read       = 1'b1;
        req.read_index = index;
        @(negedge clk);
        req.read = 1'b0;
        check("read_valid", 64'd1, 64'(rsp.read_valid));
        check("read_data", 64'(exp_data), 64'(rsp.read_data));
        check("read_resp", 64'(exp_resp), 64'(rsp.read_resp));
    endtask

    // Random good and bad counts that overlap in time
    task automatic packet_burst(input logic [31:0] max_count);
        int good_n;
        int bad_n;
        rnd    = next_random(rnd);
        good_n = int'((rnd >> 8) % (max_count + 32'd1));
        rnd    = next_random(rnd);
        bad_n  = int'((rnd >> 8) % (max_count + 32'd1));
        for (int i = 0; i < good_n || i < bad_n; i++) begin
            @(negedge clk);
            events.good = (i < good_n);
            events.bad  = (i < bad_n);
        end
        @(negedge clk);
        events     = '0;
        good_total = good_total + 64'(good_n);
        bad_total  = bad_total + 64'(bad_n);
        read_reg(REG_GOOD_L, good_total[31:0], OKAY);
        read_reg(REG_GOOD_H, good_total[63:32], OKAY);
        read_reg(REG_BAD_L, bad_total[31:0], OKAY);
        read_reg(REG_BAD_H, bad_total[63:32], OKAY);
    endtask

    task automatic range_strobe();
        @(negedge clk);
        events.range_err = 1'b1;
        @(negedge clk);
        events.range_err = 1'b0;
    endtask

    // A stalled beat with a wrong field comes first and must be ignored
    task automatic stream_beat(input logic [31:0] field);
        @(negedge clk);
        seq.tdata = '0;
        seq.tdata[`NIC_SEQ_TDATA_W-1 -: `NIC_SEQ_FIELD_W] = field + 32'd5;
        seq.tvalid = 1'b1;
        seq.tready = 1'b0;
        @(negedge clk);
        seq.tdata[`NIC_SEQ_TDATA_W-1 -: `NIC_SEQ_FIELD_W] = field;
        seq.tready = 1'b1;
        @(negedge clk);
        seq.tvalid = 1'b0;
        seq.tready = 1'b0;
    endtask

    // High from one cycle after the strobe and counted until it drops
    task automatic pause_check(input logic [31:0] cycles_n, input logic [31:0] expected);
        int high;
        high = 0;
        write_reg(REG_PAUSE_PCI, cycles_n, OKAY);
        while (pause_pci && high < int'(cycles_n) + 4) begin
            high++;
            @(negedge clk);
        end
        check("pause_pci high cycles", 64'(expected), 64'(high));
    endtask

    // Low from two cycles after the strobe while RESET reads 1 in the middle
    task automatic soft_reset_check(input logic [31:0] expected);
        int low;
        low = 0;
        write_reg(REG_RESET, 32'd0, OKAY);
        check("resetn_out before countdown", 64'd1, 64'(resetn_out));
        @(negedge clk);
        while (!resetn_out && low < `NIC_RESET_CYCLES + 4) begin
            low++;
            if (low == 4) begin
                req.read       = 1'b1;
                req.read_index = REG_RESET;
            end
            if (low == 5) begin
                req.read = 1'b0;
                check("reset busy valid", 64'd1, 64'(rsp.read_valid));
                check("reset busy data", 64'd1, 64'(rsp.read_data));
            end
            @(negedge clk);
        end
        check("resetn_out low cycles", 64'(expected), 64'(low));
        good_total = '0;
        bad_total  = '0;
    endtask

    // ==============================
    // Vector file
    // ==============================
    task automatic load_vectors();
        int          fd;
        int          got;
        string       line;
        logic [7:0]  op;
        logic [7:0]  idx;
        logic [31:0] data;
        logic [63:0] exp_val;
        fd = $fopen("sim/nic_control_vectors.txt", "r");
        if (fd == 0) begin
            abort_run("Cannot open sim/nic_control_vectors.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got  = $fgets(line, fd);
                // Skip blank and comment lines
                if (got > 0 && line.len() > 2 && line[0] != "#") begin
                    got = $sscanf(line, "%c %h %h %h", op, idx, data, exp_val);
                    if (got != 4) begin
                        abort_run($sformatf("Malformed vector line: %s", line));
                    end
                    op_q.push_back(op);
                    idx_q.push_back(idx);
                    data_q.push_back(data);
                    exp_q.push_back(exp_val);
                end
            end
            $fclose(fd);
            vectors_loaded = 1'b1;
        end
    endtask

    task automatic run_vector(input int n);
        logic [7:0]  op;
        logic [7:0]  idx;
        logic [31:0] data;
        logic [63:0] exp_val;
        op        = op_q[n];
        idx       = idx_q[n];
        data      = data_q[n];
        exp_val   = exp_q[n];
        test_name = $sformatf("vector %0d op %c index %h", n, op, idx);
        case (op)
            "W": begin
                write_reg(idx, data, exp_val[1:0]);
                if (idx == REG_CLEAR_COUNTERS) begin
                    good_total = '0;
                    bad_total  = '0;
                end
            end
            "R": read_reg(idx, exp_val[31:0], OKAY);
            "U": read_reg(idx, exp_val[31:0], DECERR);
            "K": begin
                write_reg(idx, data, OKAY);
                check("cfg packet_count", exp_val, cfg.packet_count);
            end
            "N": packet_burst(data);
            "E": range_strobe();
            "O": begin
                @(negedge clk);
                overflow_0 = data[0];
                overflow_1 = data[1];
            end
            "Q": stream_beat(data);
            "P": pause_check(data, exp_val[31:0]);
            "S": soft_reset_check(exp_val[31:0]);
            default: abort_run($sformatf("Unknown operation in vector %0d", n));
        endcase
    endtask

    // ==============================
    // Main sequence
    // ==============================
    initial begin
        req            = '0;
        events         = '0;
        seq            = '0;
        overflow_0     = 1'b0;
        overflow_1     = 1'b0;
        hbm_cattrip    = 1'b0;
        pcs_aligned    = 1'b1;
        generator_idle = 1'b1;
        good_total     = '0;
        bad_total      = '0;
        rnd            = 32'h65d6876f;
        error_count    = 0;
        test_name      = "reset state";
        load_vectors();
        // Outputs while reset is held, first falling edge after a clocked reset
        @(posedge clk);
        @(negedge clk);
        check("gen_packets in reset", 64'd0, 64'(gen_packets));
        check("pause_pci in reset", 64'd0, 64'(pause_pci));
        check("write_done in reset", 64'd0, 64'(rsp.write_done));
        check("read_valid in reset", 64'd0, 64'(rsp.read_valid));
        check("resetn_out in reset", 64'd0, 64'(resetn_out));
        @(posedge resetn);
        @(negedge clk);
        for (int n = 0; n < op_q.size(); n++) begin
            run_vector(n);
        end
        if (error_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            abort_run($sformatf("%0d checks did not match", error_count));
        end
    end

    // Budget per vector plus the software reset countdown
    initial begin
        wait (vectors_loaded);
        repeat (op_q.size() * 64 + 2 * `NIC_RESET_CYCLES + 32) @(posedge clk);
        abort_run("Timeout: the vectors did not complete in the expected time");
    end

endmodule

//--- src.f
+incdir+include
design/nic_reg_pkg.sv
design/nic_status_pkg.sv
design/ctrl_regs.sv
design/status_monitor.sv
design/reg_read_mux.sv
design/nic_control.sv
sim/clk_gen.sv
sim/nic_control_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the NIC control testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f src.f \
    --top-module nic_control_tb \
    -o nic_control_sim \
    && ./obj_dir/nic_control_sim \
    || { echo "nic_control simulation did not pass"; exit 1; }

//--- sim/nic_control_vectors.txt
# op index data expected, all hex; W expects resp, R/U expect data, K expects packet count
# N bursts up to data strobes, E range, O overflow=data, Q field=data, P/S expect cycles
R 06 0 00000001
R 07 0 00000000
R 08 0 00000001
R 09 0 00000000
R 22 0 0
R 03 0 0
R 05 0 0
R 01 0 0
R 00 0 3
W 06 12345678 0
W 07 9abcdef0 0
R 06 0 12345678
R 07 0 9abcdef0
W 09 00100000 0
R 09 0 00100000
W 22 1 0
R 22 0 1
W 40 55 3
U 40 0 0
W 01 7 3
U 0b 0 0
W 20 00000002 0
K 21 00000080 0000000200000080
R 21 0 0
R 20 0 0
N 0 14 0
W 0b 0 0
R 03 0 0
R 05 0 0
E 0 0 0
R 01 0 1
O 0 3 0
R 01 0 7
O 0 0 0
W 0b 0 0
R 01 0 0
Q 0 0 0
Q 0 1 0
Q 0 2 0
Q 0 3 0
R 01 0 0
Q 0 7 0
R 01 0 8
W 0b 0 0
R 01 0 0
P 23 11 11
N 0 9 0
S 0a 0 3e8
R 03 0 0
R 05 0 0
R 0a 0 0
R 06 0 12345678
